// File: build.f
fir_pkg.sv
wb_pkg.sv
coef_bank.sv
tap_delay_line.sv
tap_multiply.sv
tap_sum.sv
fir_filter_top.sv
tb_clock_gen.sv
fir_filter_properties.sv
fir_filter_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run the FIR testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fir_filter_tb -f build.f \
    || { echo "run_sim: build failed"; exit 1; }

sim_out=$(./obj_dir/Vfir_filter_tb)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "TEST PASSED" \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }

// File: fir_filter_tb.sv
`timescale 1ns/100ps

module fir_filter_tb;
    import fir_pkg::*;
    import wb_pkg::*;

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    sample_t sample;
    logic    sample_valid;
    sum_t    out;
    logic    out_valid;

    // reference model, coefficients as written and sample history newest first
    int   model_coef[NUM_TAPS] = '{default: 0};
    int   hist[NUM_TAPS] = '{default: 0};
    logic window_pending = 1'b0;
    int   exp_q[$];
    int   accept_q[$];
    int   out_seen[$];
    int   accepted_count = 0;
    int   cycle_count = 0;

    int   test_errors = 0;
    int   stream_errors = 0;
    int   seed = 32'he11693be;

    tb_clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fir_filter_top fir_filter_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .sample       (sample),
        .sample_valid (sample_valid),
        .out          (out),
        .out_valid    (out_valid)
    );

    task automatic show_mismatch(input string name, input int expected, input int got);
        $display("error at %0t ns: %s expected %0d, got %0d", $time, name, expected, got);
    endtask

    // convolution over the model history
    function automatic int model_output();
        int acc;
        acc = 0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            acc += model_coef[i] * hist[i];
        end
        return acc;
    endfunction

    // inputs are read at the rising edge, DUT outputs at the falling edge
    initial begin : scoreboard
        int expected;
        int got;
        int latency;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                cycle_count++;
                // products of the previous window are registered at this edge
                if (window_pending) begin
                    exp_q.push_back(model_output());
                    window_pending = 1'b0;
                end
                if (sample_valid) begin
                    for (int i = NUM_TAPS - 1; i > 0; i--) begin
                        hist[i] = hist[i-1];
                    end
                    hist[0] = int'(sample);
                    accept_q.push_back(cycle_count);
                    accepted_count++;
                    window_pending = 1'b1;
                end
            end
            @(negedge clk);
            if (out_valid) begin
                got = int'(out);
                out_seen.push_back(got);
                if (exp_q.size() == 0) begin
                    stream_errors++;
                    $display("out_valid at %0t ns with no accepted sample pending", $time);
                end else begin
                    expected = exp_q.pop_front();
                    // out_valid is taken by the edge after the one that set it
                    latency = cycle_count + 1 - accept_q.pop_front();
                    if (got != expected) begin
                        stream_errors++;
                        show_mismatch("out", expected, got);
                    end
                    if (latency != 3) begin
                        stream_errors++;
                        show_mismatch("out_valid latency", 3, latency);
                    end
                end
            end
        end
    end

    task automatic bus_access(input logic we, input int adr, input int wdata,
                              output int rdata, output logic ok);
        int waited;
        waited = 0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = we;
        wb_req.adr = WB_ADR_W'(adr);
        wb_req.dat_w = WB_DAT_W'(wdata);
        @(negedge clk);
        while (!wb_rsp.ack && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        rdata = int'(wb_rsp.dat_r);
        ok = wb_rsp.ack;
        if (!ok) begin
            test_errors++;
            $display("bus access to address %0d got no ack by %0t ns", adr, $time);
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we = 1'b0;
    endtask

    task automatic write_coef(input int adr, input int data);
        int   rd;
        int   low;
        logic ok;
        bus_access(1'b1, adr, data, rd, ok);
        // only the low nine bits are kept, taken as two's complement
        if (ok && adr < NUM_TAPS) begin
            low = data & 'h1ff;
            if (low > 255) begin
                model_coef[adr] = low - 512;
            end else begin
                model_coef[adr] = low;
            end
        end
    endtask

    task automatic read_check(input int adr);
        int   got;
        int   expected;
        logic ok;
        bus_access(1'b0, adr, 0, got, ok);
        expected = 0;
        if (adr < NUM_TAPS) begin
            expected = model_coef[adr] & 'hffff;
        end
        if (ok && got != expected) begin
            test_errors++;
            show_mismatch("wb_rsp.dat_r", expected, got);
        end
    endtask

    task automatic send_sample(input int value);
        sample = sample_t'(value);
        sample_valid = 1'b1;
        @(negedge clk);
        sample_valid = 1'b0;
    endtask

    task automatic wait_outputs(input int target);
        int waited;
        waited = 0;
        while (out_seen.size() < target && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (out_seen.size() < target) begin
            test_errors++;
            $display("only %0d of %0d filter outputs arrived", out_seen.size(), target);
        end
    endtask

    task automatic check_reset_state();
        if (out_valid !== 1'b0) begin
            test_errors++;
            show_mismatch("out_valid", 0, int'(out_valid));
        end
        if (out !== '0) begin
            test_errors++;
            show_mismatch("out", 0, int'(out));
        end
        for (int i = 0; i < NUM_TAPS; i++) begin
            read_check(i);
        end
    endtask

    task automatic check_coef_access();
        int value;
        // negative values included, upper data bits set to junk
        for (int i = 0; i < NUM_TAPS; i++) begin
            value = i * 53 - 240;
            write_coef(i, (value & 'h1ff) | 'hfe00);
        end
        for (int i = 0; i < NUM_TAPS; i++) begin
            read_check(i);
        end
        write_coef(12, 'h00ff);
        read_check(12);
        for (int i = 0; i < NUM_TAPS; i++) begin
            read_check(i);
        end
    endtask

    task automatic run_inverter();
        int wave[16] = '{0, 59, 106, 138, 150, 138, 106, 59,
                         0, -59, -106, -138, -150, -138, -106, -59};
        int base;
        write_coef(0, -1);
        for (int i = 1; i < NUM_TAPS; i++) begin
            write_coef(i, 0);
        end
        base = out_seen.size();
        for (int j = 0; j < 16; j++) begin
            send_sample(wave[j]);
        end
        wait_outputs(base + 16);
        for (int j = 0; j < 16 && base + j < out_seen.size(); j++) begin
            if (out_seen[base + j] != -wave[j]) begin
                test_errors++;
                show_mismatch("out", -wave[j], out_seen[base + j]);
            end
        end
    endtask

    task automatic run_delay_amplifier();
        int vals[12] = '{17, -33, 48, 101, -90, 5, 77, -128, 64, -1, 30, -45};
        int base;
        int expected;
        for (int i = 0; i < NUM_TAPS; i++) begin
            write_coef(i, (i == 7) ? 5 : 0);
        end
        // flush older samples out of the delay line
        base = out_seen.size();
        for (int j = 0; j < NUM_TAPS; j++) begin
            send_sample(0);
        end
        wait_outputs(base + NUM_TAPS);
        base = out_seen.size();
        for (int j = 0; j < 12; j++) begin
            send_sample(vals[j]);
        end
        wait_outputs(base + 12);
        for (int j = 0; j < 12 && base + j < out_seen.size(); j++) begin
            expected = 0;
            if (j >= 7) begin
                expected = 5 * vals[j - 7];
            end
            if (out_seen[base + j] != expected) begin
                test_errors++;
                show_mismatch("out", expected, out_seen[base + j]);
            end
        end
    endtask

    task automatic run_random_filter();
        int base_out;
        int base_acc;
        for (int i = 0; i < NUM_TAPS; i++) begin
            write_coef(i, $random(seed) % 256);
        end
        base_out = out_seen.size();
        base_acc = accepted_count;
        for (int j = 0; j < 80; j++) begin
            if (($random(seed) & 3) == 0) begin
                @(negedge clk);
            end else begin
                send_sample($random(seed) % 256);
            end
        end
        wait_outputs(base_out + accepted_count - base_acc);
        if (out_seen.size() - base_out != accepted_count - base_acc) begin
            test_errors++;
            show_mismatch("out_valid pulses", accepted_count - base_acc,
                          out_seen.size() - base_out);
        end
    endtask

    task automatic run_latency_check();
        int base;
        for (int i = 0; i < NUM_TAPS; i++) begin
            write_coef(i, i + 1);
        end
        base = out_seen.size();
        fork
            begin
                for (int j = 0; j < 24; j++) begin
                    send_sample(j * 11 - 120);
                end
            end
            begin
                // retune one tap while samples stream back to back
                repeat (9) @(negedge clk);
                write_coef(3, -77);
            end
        join
        wait_outputs(base + 24);
        read_check(3);
    endtask

    initial begin
        int waited;
        wb_req = '0;
        sample = '0;
        sample_valid = 1'b0;
        waited = 0;
        while (rst_n !== 1'b1 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            test_errors++;
            $display("reset was never released");
        end
        @(negedge clk);
        check_reset_state();
        check_coef_access();
        run_inverter();
        run_delay_amplifier();
        run_random_filter();
        run_latency_check();
        $display("errors: %0d in tests, %0d in output stream", test_errors, stream_errors);
        if (test_errors == 0 && stream_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: fir_filter_properties.sv
`timescale 1ns/100ps

module fir_filter_properties (
    input logic            clk,
    input logic            rst_n,
    input wb_pkg::wb_req_t wb_req,
    input wb_pkg::wb_rsp_t wb_rsp,
    input logic            sample_valid,
    input logic            out_valid
);

    // one request, one ack
    ack_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack
    ) else $error("ack held for more than one cycle");

    ack_needs_request: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb)
    ) else $error("ack without an active bus request");

    // three register stages between an accepted sample and out_valid
    out_valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid == $past(sample_valid, 3)
    ) else $error("out_valid does not follow sample_valid by three clocks");

endmodule

bind fir_filter_top fir_filter_properties fir_filter_properties_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .sample_valid (sample_valid),
    .out_valid    (out_valid)
);

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // reset held for ten cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: fir_filter_top.sv
`timescale 1ns/100ps

module fir_filter_top (
    input  logic             clk,
    input  logic             rst_n,
    input  wb_pkg::wb_req_t  wb_req,
    output wb_pkg::wb_rsp_t  wb_rsp,
    input  fir_pkg::sample_t sample,
    input  logic             sample_valid,
    output fir_pkg::sum_t    out,
    output logic             out_valid
);
    import fir_pkg::*;

    coef_set_t      coef_set;
    window_stage_t  window;
    product_stage_t products;

    // bus side, impulse response registers
    coef_bank coef_bank_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .coef_set (coef_set)
    );

    // stage 1
    tap_delay_line tap_delay_line_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .window       (window)
    );

    // stage 2
    tap_multiply tap_multiply_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .window   (window),
        .coef_set (coef_set),
        .products (products)
    );

    // stage 3
    tap_sum tap_sum_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .products  (products),
        .out       (out),
        .out_valid (out_valid)
    );

endmodule

// File: tap_sum.sv
`timescale 1ns/100ps

module tap_sum (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fir_pkg::product_stage_t products,
    output fir_pkg::sum_t           out,
    output logic                    out_valid
);
    import fir_pkg::*;

    sum_t sum_d;

    // adder chain over all taps, each product sign-extended first
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            sum_d = sum_d + sum_t'($signed(products.prod[i]));
        end
    end

    // out holds the last result between samples
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out <= '0;
        end else if (products.valid) begin
            out <= sum_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= products.valid;
        end
    end

endmodule

// File: tap_multiply.sv
`timescale 1ns/100ps

module tap_multiply (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fir_pkg::window_stage_t  window,
    input  fir_pkg::coef_set_t      coef_set,
    output fir_pkg::product_stage_t products
);
    import fir_pkg::*;

    product_set_t prod_d;

    // full-width signed products, operands widened before the multiply
    always_comb begin
        for (int i = 0; i < NUM_TAPS; i++) begin
            prod_d[i] = product_t'($signed(window.taps[i]))
                      * product_t'($signed(coef_set[i]));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            products <= '0;
        end else begin
            products.valid <= window.valid;
            // products only move with a new window
            if (window.valid) begin
                products.prod <= prod_d;
            end
        end
    end

endmodule

// File: tap_delay_line.sv
`timescale 1ns/100ps

module tap_delay_line (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fir_pkg::sample_t       sample,
    input  logic                   sample_valid,
    output fir_pkg::window_stage_t window
);
    import fir_pkg::*;

    tap_window_t taps_q;
    logic        valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            taps_q <= '0;
        end else if (sample_valid) begin
            // oldest sample drops off the end
            taps_q[0] <= sample;
            for (int i = 1; i < NUM_TAPS; i++) begin
                taps_q[i] <= taps_q[i-1];
            end
        end
    end

    // window is fresh only in the cycle after a shift
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= sample_valid;
        end
    end

    assign window.valid = valid_q;
    assign window.taps = taps_q;

endmodule

// File: coef_bank.sv
`timescale 1ns/100ps

module coef_bank (
    input  logic               clk,
    input  logic               rst_n,
    input  wb_pkg::wb_req_t    wb_req,
    output wb_pkg::wb_rsp_t    wb_rsp,
    output fir_pkg::coef_set_t coef_set
);
    import fir_pkg::*;
    import wb_pkg::*;

    logic                req_new;
    logic                addr_hit;
    logic                wr_en;
    coef_t               rd_coef;
    logic [WB_DAT_W-1:0] rd_data;

    // a request counts once; the cycle that carries ack does not start another
    assign req_new = wb_req.cyc && wb_req.stb && !wb_rsp.ack;

    // addresses 0 .. NUM_TAPS-1 map to the coefficient registers
    assign addr_hit = (wb_req.adr < WB_ADR_W'(NUM_TAPS));

    assign wr_en = req_new && wb_req.we && addr_hit;

    // unmapped addresses read as zero
    always_comb begin
        rd_coef = '0;
        if (addr_hit) begin
            rd_coef = coef_set[wb_req.adr];
        end
    end

    // sign-extend to the bus width
    assign rd_data = {{(WB_DAT_W - COEF_W){rd_coef[COEF_W-1]}}, rd_coef};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_rsp <= '0;
        end else begin
            wb_rsp.ack <= req_new;
            if (req_new) begin
                wb_rsp.dat_r <= rd_data;
            end
        end
    end

    // new coefficient lands on the same edge that raises ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coef_set <= '0;
        end else if (wr_en) begin
            coef_set[wb_req.adr] <= wb_req.dat_w[COEF_W-1:0];
        end
    end

endmodule

// File: wb_pkg.sv
package wb_pkg;

    localparam int WB_ADR_W = 4;
    localparam int WB_DAT_W = 16;

    // master to slave signals of a Wishbone classic cycle
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat_w;
    } wb_req_t;

    // slave to master signals
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat_r;
    } wb_rsp_t;

endpackage

// File: fir_pkg.sv
package fir_pkg;

    // filter geometry
    localparam int NUM_TAPS = 10;

    // datapath widths
    localparam int SAMPLE_W = 9;
    localparam int COEF_W = 9;
    localparam int PRODUCT_W = SAMPLE_W + COEF_W;

    // ten full-scale products need three guard bits over one product
    localparam int SUM_W = 21;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic signed [PRODUCT_W-1:0] product_t;
    typedef logic signed [SUM_W-1:0] sum_t;

    // element 0 holds the newest sample
    typedef sample_t [NUM_TAPS-1:0] tap_window_t;

    // element i weights the sample that is i steps old
    typedef coef_t [NUM_TAPS-1:0] coef_set_t;

    typedef product_t [NUM_TAPS-1:0] product_set_t;

    // output of the delay line, valid for one cycle per accepted sample
    typedef struct packed {
        logic        valid;
        tap_window_t taps;
    } window_stage_t;

    // output of the multiply stage
    typedef struct packed {
        logic         valid;
        product_set_t prod;
    } product_stage_t;

endpackage
